//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= all.f
TOP       ?= tb_rv_core
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "No pass line found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
verilog/rv_pkg.sv
verilog/mem_bus_if.sv
verilog/register_file.sv
verilog/exec_unit.sv
verilog/instr_sequencer.sv
verilog/load_store_unit.sv
verilog/mem_arbiter.sv
verilog/rv_core_top.sv
tests/tb_rv_core.sv

//--- tests/tb_rv_core.sv
module tb_rv_core;

    localparam int          MEM_WORDS    = 512;
    localparam logic [31:0] DATA_BASE    = 32'h400;
    localparam int          STORE_WAIT   = 300;
    localparam int          HALT_WAIT    = 300;
    localparam int          QUIET_CYCLES = 50;

    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;

    logic        clock = 1'b0;
    logic        reset;
    logic        mem_valid;
    logic [31:0] mem_addr;
    logic        mem_write;
    logic [31:0] mem_wdata;
    logic        mem_ready;
    logic [31:0] mem_rdata;
    logic        halted;

    logic [31:0] mem [0:MEM_WORDS-1];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] pc_next;   // Byte address of the next emitted instruction
    logic [31:0] slot_addr; // Next free store slot
    integer      seed = 52;
    int          wait_left;

    rv_core_top #(
        .RESET_PC (32'h0)
    ) rv_core_top_inst (
        .clock     (clock),
        .reset     (reset),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    always #4 clock = ~clock;

    // Memory model with one cycle plus a random delay before ready
    always @(posedge clock) begin
        if (reset) begin
            mem_ready <= 1'b0;
        end else if (mem_valid && mem_ready) begin
            if (mem_write) begin
                mem[mem_addr[10:2]] <= mem_wdata;
            end
            mem_ready <= 1'b0;
            wait_left <= $unsigned($random(seed)) % 4;
        end else if (mem_valid) begin
            if (wait_left == 0) begin
                mem_ready <= 1'b1;
                mem_rdata <= mem[mem_addr[10:2]];
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

    function automatic logic [31:0] r_word(logic [6:0] f7, int rs2, int rs1,
                                           logic [2:0] f3, int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic logic [31:0] i_word(int imm, int rs1, logic [2:0] f3, int rd,
                                           logic [6:0] opc);
        logic [31:0] v;
        v = imm;
        return {v[11:0], 5'(rs1), f3, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] s_word(int imm, int rs2, int rs1);
        logic [31:0] v;
        v = imm;
        return {v[11:5], 5'(rs2), 5'(rs1), 3'b010, v[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_word(int off, int rs1, int rs2, logic [2:0] f3);
        logic [31:0] v;
        v = off;
        return {v[12], v[10:5], 5'(rs2), 5'(rs1), f3, v[4:1], v[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_word(logic [19:0] imm, int rd, logic [6:0] opc);
        return {imm, 5'(rd), opc};
    endfunction

    function automatic logic [31:0] j_word(int off, int rd);
        logic [31:0] v;
        v = off;
        return {v[20], v[10:1], v[11], v[19:12], 5'(rd), OP_JAL};
    endfunction

    task automatic put_instr(input logic [31:0] w);
        mem[pc_next[10:2]] = w;
        pc_next += 4;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // SW rs to a fresh slot; off-path stores are left out of the table
    task automatic store_reg(input int rs, input bit on_path, input logic [31:0] value);
        put_instr(s_word(int'(slot_addr), rs, 0));
        if (on_path) begin
            expect_store(slot_addr, value);
        end
        slot_addr += 4;
    endtask

    task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2,
                               input bit taken, input int marker);
        put_instr(b_word(12, rs1, rs2, f3)); // Skips the first marker
        put_instr(i_word(marker, 0, 3'b000, 23, OP_IMM));
        store_reg(23, !taken, marker);
        put_instr(i_word(marker + 1, 0, 3'b000, 23, OP_IMM));
        store_reg(23, 1'b1, marker + 1);
    endtask

    task automatic build_program();
        logic [31:0] here;
        logic [31:0] slot;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[9'(i)] = {16'hA5C3, 16'(i)};
        end
        pc_next   = 32'h0;
        slot_addr = DATA_BASE;
        // x1 = 100, x2 = -7 feed most of the later cases
        put_instr(i_word(100, 0, 3'b000, 1, OP_IMM));
        store_reg(1, 1'b1, 32'd100);
        put_instr(i_word(-7, 0, 3'b000, 2, OP_IMM));
        store_reg(2, 1'b1, 32'hFFFF_FFF9);
        put_instr(i_word(-6, 2, 3'b010, 3, OP_IMM));
        store_reg(3, 1'b1, 32'd1);
        put_instr(i_word(5, 2, 3'b011, 4, OP_IMM));
        store_reg(4, 1'b1, 32'd0);
        put_instr(i_word(32'h0FF, 1, 3'b100, 5, OP_IMM));
        store_reg(5, 1'b1, 32'h9B);
        put_instr(i_word(32'h700, 1, 3'b110, 6, OP_IMM));
        store_reg(6, 1'b1, 32'h764);
        put_instr(i_word(32'h0F0, 2, 3'b111, 7, OP_IMM));
        store_reg(7, 1'b1, 32'hF0);
        put_instr(i_word(4, 1, 3'b001, 8, OP_IMM));
        store_reg(8, 1'b1, 32'h640);
        put_instr(i_word(28, 2, 3'b101, 9, OP_IMM)); // x9 = 15 is the shift amount below
        store_reg(9, 1'b1, 32'hF);
        put_instr(i_word(32'h401, 2, 3'b101, 10, OP_IMM)); // SRAI by 1
        store_reg(10, 1'b1, 32'hFFFF_FFFC);

        put_instr(r_word(7'h00, 2, 1, 3'b000, 11));
        store_reg(11, 1'b1, 32'd93);
        put_instr(r_word(7'h20, 2, 1, 3'b000, 12));
        store_reg(12, 1'b1, 32'd107);
        put_instr(r_word(7'h00, 1, 2, 3'b010, 13));
        store_reg(13, 1'b1, 32'd1);
        put_instr(r_word(7'h00, 1, 2, 3'b011, 14));
        store_reg(14, 1'b1, 32'd0);
        put_instr(r_word(7'h00, 2, 1, 3'b100, 15));
        store_reg(15, 1'b1, 32'hFFFF_FF9D);
        put_instr(r_word(7'h00, 2, 1, 3'b110, 16));
        store_reg(16, 1'b1, 32'hFFFF_FFFD);
        put_instr(r_word(7'h00, 2, 1, 3'b111, 17));
        store_reg(17, 1'b1, 32'h60);
        put_instr(r_word(7'h00, 9, 1, 3'b001, 18));
        store_reg(18, 1'b1, 32'h0032_0000);
        put_instr(r_word(7'h00, 9, 2, 3'b101, 19));
        store_reg(19, 1'b1, 32'h0001_FFFF);
        put_instr(r_word(7'h20, 9, 2, 3'b101, 20));
        store_reg(20, 1'b1, 32'hFFFF_FFFF);
        put_instr(u_word(20'h12345, 21, OP_LUI));
        store_reg(21, 1'b1, 32'h1234_5000);
        here = pc_next;
        put_instr(u_word(20'h00001, 22, OP_AUIPC));
        store_reg(22, 1'b1, here + 32'h1000);
        put_instr(i_word(5, 1, 3'b000, 0, OP_IMM)); // Write to x0 is dropped
        store_reg(0, 1'b1, 32'd0);

        branch_case(3'b000, 1, 1, 1'b1, 32'h100);
        branch_case(3'b000, 1, 2, 1'b0, 32'h102);
        branch_case(3'b001, 1, 2, 1'b1, 32'h104);
        branch_case(3'b001, 1, 1, 1'b0, 32'h106);
        branch_case(3'b100, 2, 1, 1'b1, 32'h108);
        branch_case(3'b100, 1, 2, 1'b0, 32'h10A);
        branch_case(3'b101, 1, 2, 1'b1, 32'h10C);
        branch_case(3'b101, 2, 1, 1'b0, 32'h10E);
        branch_case(3'b110, 1, 2, 1'b1, 32'h110);
        branch_case(3'b110, 2, 1, 1'b0, 32'h112);
        branch_case(3'b111, 2, 1, 1'b1, 32'h114);
        branch_case(3'b111, 1, 2, 1'b0, 32'h116);

        here = pc_next;
        put_instr(j_word(12, 25));
        put_instr(i_word(32'h7FF, 0, 3'b000, 23, OP_IMM));
        store_reg(23, 1'b0, 32'h0);
        store_reg(25, 1'b1, here + 4);
        here = pc_next + 4; // Address of the JALR
        put_instr(i_word(int'(here) + 9, 0, 3'b000, 26, OP_IMM)); // Odd target before masking
        put_instr(i_word(4, 26, 3'b000, 27, OP_JALR));
        put_instr(i_word(32'h7FE, 0, 3'b000, 23, OP_IMM));
        store_reg(23, 1'b0, 32'h0);
        put_instr(u_word(20'h00000, 24, OP_AUIPC)); // Landing address
        store_reg(27, 1'b1, here + 4);
        store_reg(24, 1'b1, here + 12);

        slot = slot_addr;
        store_reg(1, 1'b1, 32'd100);
        put_instr(i_word(int'(DATA_BASE), 0, 3'b000, 29, OP_IMM));
        put_instr(i_word(int'(slot - DATA_BASE), 29, 3'b010, 28, OP_LOAD));
        put_instr(i_word(23, 28, 3'b000, 28, OP_IMM));
        put_instr(s_word(int'(slot - DATA_BASE), 28, 29));
        expect_store(slot, 32'd123);
        put_instr(i_word(int'(slot - DATA_BASE), 29, 3'b010, 30, OP_LOAD));
        store_reg(30, 1'b1, 32'd123);
        put_instr(32'h0000_0073); // ECALL is illegal in this core
    endtask

    task automatic wait_store(input int index);
        int cycles;
        cycles = 0;
        @(posedge clock);
        while (!(mem_valid && mem_ready && mem_write)) begin
            cycles++;
            assert (cycles < STORE_WAIT) else begin
                $display("Timed out at %0t waiting for store number %0d", $time, index);
                $display("Result: FAILED");
                $fatal(1);
            end
            @(posedge clock);
        end
    endtask

    task automatic wait_halt();
        int cycles;
        cycles = 0;
        @(posedge clock);
        while (!halted) begin
            cycles++;
            assert (!(mem_valid && mem_ready && mem_write)) else begin
                $display("Store to %h at %0t came after the last expected one", mem_addr, $time);
                $display("Result: FAILED");
                $fatal(1);
            end
            assert (cycles < HALT_WAIT) else begin
                $display("Timed out at %0t waiting for halted to rise", $time);
                $display("Result: FAILED");
                $fatal(1);
            end
            @(posedge clock);
        end
    endtask

    task automatic check_quiet();
        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(posedge clock);
            assert (!mem_valid) else begin
                $display("[ERROR] time=%0t signal=mem_valid expected=0 actual=%b",
                         $time, mem_valid);
                $display("Result: FAILED");
                $fatal(1);
            end
        end
    endtask

    initial begin
        reset     = 1'b1;
        mem_ready = 1'b0;
        mem_rdata = '0;
        wait_left = 0;
        build_program();
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        for (int k = 0; k < exp_addr.size(); k++) begin
            wait_store(k);
            assert (mem_addr == exp_addr[k]) else begin
                $display("[ERROR] time=%0t signal=mem_addr expected=%h actual=%h",
                         $time, exp_addr[k], mem_addr);
                $display("Result: FAILED");
                $fatal(1);
            end
            assert (mem_wdata == exp_data[k]) else begin
                $display("[ERROR] time=%0t signal=mem_wdata expected=%h actual=%h",
                         $time, exp_data[k], mem_wdata);
                $display("Result: FAILED");
                $fatal(1);
            end
        end

        wait_halt();
        check_quiet();
        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- verilog/exec_unit.sv
module exec_unit import rv_pkg::*; (
    input  word_t      instr,
    input  word_t      pc,
    output reg_idx_t   rs1_idx,
    output reg_idx_t   rs2_idx,
    input  word_t      rs1_val,
    input  word_t      rs2_val,
    output reg_idx_t   rd_idx,
    output exec_kind_t kind,
    output word_t      result,
    output word_t      next_pc,
    output word_t      ls_addr,
    output word_t      store_data
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      alu_b;
    word_t      alu_res;
    word_t      pc_plus4;
    word_t      jalr_sum;
    alu_op_t    alu_op;
    logic       f7_ok;
    logic       shift_imm;
    logic       legal;
    logic       taken;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign pc_plus4   = pc + 32'd4;
    assign jalr_sum   = rs1_val + imm_i;
    assign alu_b      = (opcode == OPC_OP_IMM) ? imm_i : rs2_val;
    assign ls_addr    = rs1_val + ((opcode == OPC_STORE) ? imm_s : imm_i);
    assign store_data = rs2_val;

    always_comb begin
        case (funct3)
            F3_ADD_SUB: alu_op = (opcode == OPC_OP && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
            F3_SLL:     alu_op = ALU_SLL;
            F3_SLT:     alu_op = ALU_SLT;
            F3_SLTU:    alu_op = ALU_SLTU;
            F3_XOR:     alu_op = ALU_XOR;
            F3_SRL_SRA: alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            F3_OR:      alu_op = ALU_OR;
            default:    alu_op = ALU_AND;
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_res = rs1_val + alu_b;
            ALU_SUB:  alu_res = rs1_val - alu_b;
            ALU_SLT:  alu_res = word_t'($signed(rs1_val) < $signed(alu_b));
            ALU_SLTU: alu_res = word_t'(rs1_val < alu_b);
            ALU_XOR:  alu_res = rs1_val ^ alu_b;
            ALU_OR:   alu_res = rs1_val | alu_b;
            ALU_AND:  alu_res = rs1_val & alu_b;
            ALU_SLL:  alu_res = rs1_val << alu_b[4:0];
            ALU_SRL:  alu_res = rs1_val >> alu_b[4:0];
            ALU_SRA:  alu_res = word_t'($signed(rs1_val) >>> alu_b[4:0]);
            default:  alu_res = '0;
        endcase
    end

    // SUB and SRA are the only alternate encodings
    assign f7_ok = (funct7 == F7_BASE) ||
                   (funct7 == F7_ALT && (funct3 == F3_SRL_SRA ||
                   (funct3 == F3_ADD_SUB && opcode == OPC_OP)));
    assign shift_imm = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

    always_comb begin
        case (opcode)
            OPC_OP_IMM: legal = !shift_imm || f7_ok;
            OPC_OP:     legal = f7_ok;
            OPC_LUI,
            OPC_AUIPC,
            OPC_JAL:    legal = 1'b1;
            OPC_JALR:   legal = (funct3 == 3'b000);
            OPC_BRANCH: legal = (funct3[2:1] != 2'b01);
            OPC_LOAD,
            OPC_STORE:  legal = (funct3 == F3_WORD);
            default:    legal = 1'b0;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  taken = (rs1_val == rs2_val);
            F3_BNE:  taken = (rs1_val != rs2_val);
            F3_BLT:  taken = ($signed(rs1_val) < $signed(rs2_val));
            F3_BGE:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            F3_BLTU: taken = (rs1_val < rs2_val);
            F3_BGEU: taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (!legal) begin
            kind = KIND_ILLEGAL;
        end else if (opcode == OPC_LOAD) begin
            kind = KIND_LOAD;
        end else if (opcode == OPC_STORE) begin
            kind = KIND_STORE;
        end else begin
            kind = KIND_REG;
        end
    end

    // Branches and stores have no destination
    assign rd_idx = (opcode == OPC_BRANCH || opcode == OPC_STORE) ? '0 : instr[11:7];

    always_comb begin
        case (opcode)
            OPC_LUI:   result = imm_u;
            OPC_AUIPC: result = pc + imm_u;
            OPC_JAL,
            OPC_JALR:  result = pc_plus4; // Link value
            default:   result = alu_res;
        endcase
    end

    always_comb begin
        case (opcode)
            OPC_JAL:    next_pc = pc + imm_j;
            OPC_JALR:   next_pc = {jalr_sum[XLEN-1:1], 1'b0};
            OPC_BRANCH: next_pc = taken ? pc + imm_b : pc_plus4;
            default:    next_pc = pc_plus4;
        endcase
    end

endmodule

//--- verilog/instr_sequencer.sv
module instr_sequencer import rv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic         clock,
    input  logic         reset,
    mem_bus_if.requester fetch,
    output word_t        instr,
    output word_t        pc,
    input  exec_kind_t   kind,
    input  word_t        next_pc,
    output logic         rd_write,
    output logic         ls_start,
    input  logic         ls_done,
    output logic         halted
);

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_MEM,
        S_HALT
    } phase_t;

    phase_t state;
    logic   fetch_valid;
    logic   is_mem;

    assign is_mem = (kind == KIND_LOAD) || (kind == KIND_STORE);

    assign fetch.valid = fetch_valid;
    assign fetch.addr  = pc;
    assign fetch.write = 1'b0; // Fetch port never writes
    assign fetch.wdata = '0;

    assign rd_write = (state == S_EXEC && kind == KIND_REG) ||
                      (state == S_MEM && ls_done && kind == KIND_LOAD);
    assign ls_start = (state == S_EXEC) && is_mem;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= S_FETCH;
            fetch_valid <= 1'b0;
            pc          <= RESET_PC;
            halted      <= 1'b0;
        end else begin
            case (state)
                S_FETCH: begin
                    if (!fetch_valid) begin
                        fetch_valid <= 1'b1; // First fetch out of reset
                    end else if (fetch.ready) begin
                        fetch_valid <= 1'b0;
                        state       <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (kind == KIND_ILLEGAL) begin
                        halted <= 1'b1;
                        state  <= S_HALT;
                    end else if (is_mem) begin
                        state <= S_MEM;
                    end else begin
                        pc          <= next_pc;
                        fetch_valid <= 1'b1;
                        state       <= S_FETCH;
                    end
                end
                S_MEM: begin
                    if (ls_done) begin
                        pc          <= next_pc;
                        fetch_valid <= 1'b1;
                        state       <= S_FETCH;
                    end
                end
                default: state <= S_HALT; // Stays until reset
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == S_FETCH && fetch_valid && fetch.ready) begin
            instr <= fetch.rdata;
        end
    end

    // A halted core makes no more requests on either port
    assert property (@(posedge clock) disable iff (reset)
        halted |-> !fetch.valid && !ls_start);

endmodule

//--- verilog/load_store_unit.sv
module load_store_unit import rv_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    mem_bus_if.requester data,
    input  logic         start,
    input  logic         is_store,
    input  word_t        addr,
    input  word_t        wdata,
    output logic         done,
    output word_t        load_data
);

    logic  pending;
    logic  write_q;
    word_t addr_q;
    word_t wdata_q;

    assign data.valid = pending;
    assign data.addr  = addr_q;
    assign data.write = write_q;
    assign data.wdata = wdata_q;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
            done    <= 1'b0;
        end else begin
            done <= pending && data.ready; // One cycle after the transfer
            if (start) begin
                pending <= 1'b1;
            end else if (data.ready) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            addr_q  <= addr;
            write_q <= is_store;
            wdata_q <= wdata;
        end
        if (pending && data.ready) begin
            load_data <= data.rdata;
        end
    end

    // The sequencer waits for done before it can issue again
    assert property (@(posedge clock) disable iff (reset)
        start |-> !pending && !done);

endmodule

//--- verilog/mem_arbiter.sv
module mem_arbiter import rv_pkg::*; (
    input  logic         clock,
    input  logic         reset,
    mem_bus_if.responder fetch_bus,
    mem_bus_if.responder data_bus,
    output logic         mem_valid,
    output word_t        mem_addr,
    output logic         mem_write,
    output word_t        mem_wdata,
    input  logic         mem_ready,
    input  word_t        mem_rdata
);

    logic lock_valid;
    logic lock_data; // Locked owner is data_bus when set
    logic grant_data;
    logic grant_fetch;

    // Data side wins when both arrive on an idle port
    assign grant_data  = lock_valid ? lock_data : data_bus.valid;
    assign grant_fetch = lock_valid ? !lock_data : (!data_bus.valid && fetch_bus.valid);

    assign mem_valid = (grant_data && data_bus.valid) || (grant_fetch && fetch_bus.valid);
    assign mem_addr  = grant_data ? data_bus.addr  : fetch_bus.addr;
    assign mem_write = grant_data ? data_bus.write : fetch_bus.write;
    assign mem_wdata = grant_data ? data_bus.wdata : fetch_bus.wdata;

    assign data_bus.ready  = grant_data && mem_ready;
    assign fetch_bus.ready = grant_fetch && mem_ready;
    assign data_bus.rdata  = grant_data  ? mem_rdata : '0;
    assign fetch_bus.rdata = grant_fetch ? mem_rdata : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            lock_valid <= 1'b0;
            lock_data  <= 1'b0;
        end else if (mem_valid && !mem_ready) begin
            lock_valid <= 1'b1;
            lock_data  <= grant_data;
        end else if (mem_valid) begin
            lock_valid <= 1'b0; // Released on the transfer
        end
    end

    // Ready only reaches the one requester that is still asking
    assert property (@(posedge clock) disable iff (reset)
        (!data_bus.ready || data_bus.valid) && (!fetch_bus.ready || fetch_bus.valid));

    // Stalled request must hold on the outside port
    assert property (@(posedge clock) disable iff (reset)
        mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr));

endmodule

//--- verilog/mem_bus_if.sv
interface mem_bus_if;

    logic          valid;
    rv_pkg::word_t addr;
    logic          write;
    rv_pkg::word_t wdata;
    logic          ready;
    rv_pkg::word_t rdata; // Only meaningful in the transfer cycle

    modport requester (
        output valid,
        output addr,
        output write,
        output wdata,
        input  ready,
        input  rdata
    );

    modport responder (
        input  valid,
        input  addr,
        input  write,
        input  wdata,
        output ready,
        output rdata
    );

endinterface

//--- verilog/register_file.sv
module register_file import rv_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_val,
    output word_t    rs2_val,
    input  reg_idx_t rd_idx,
    input  word_t    rd_data,
    input  logic     rd_write
);

    word_t regs [1:31]; // x0 has no storage

    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write && rd_idx != '0) begin
            regs[rd_idx] <= rd_data;
        end
    end

endmodule

//--- verilog/rv_core_top.sv
module rv_core_top import rv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clock,
    input  logic  reset,
    output logic  mem_valid,
    output word_t mem_addr,
    output logic  mem_write,
    output word_t mem_wdata,
    input  logic  mem_ready,
    input  word_t mem_rdata,
    output logic  halted
);

    word_t      instr;
    word_t      pc;
    word_t      next_pc;
    word_t      result;
    word_t      ls_addr;
    word_t      store_data;
    word_t      load_data;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      rd_data;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    reg_idx_t   rd_idx;
    exec_kind_t kind;
    logic       rd_write;
    logic       ls_start;
    logic       ls_done;
    logic       is_store;

    mem_bus_if fetch_bus ();
    mem_bus_if data_bus ();

    assign is_store = (kind == KIND_STORE);
    assign rd_data  = ls_done ? load_data : result; // Load data lands in the wait phase

    instr_sequencer #(
        .RESET_PC (RESET_PC)
    ) instr_sequencer_inst (
        .clock    (clock),
        .reset    (reset),
        .fetch    (fetch_bus.requester),
        .instr    (instr),
        .pc       (pc),
        .kind     (kind),
        .next_pc  (next_pc),
        .rd_write (rd_write),
        .ls_start (ls_start),
        .ls_done  (ls_done),
        .halted   (halted)
    );

    exec_unit exec_unit_inst (
        .instr      (instr),
        .pc         (pc),
        .rs1_idx    (rs1_idx),
        .rs2_idx    (rs2_idx),
        .rs1_val    (rs1_val),
        .rs2_val    (rs2_val),
        .rd_idx     (rd_idx),
        .kind       (kind),
        .result     (result),
        .next_pc    (next_pc),
        .ls_addr    (ls_addr),
        .store_data (store_data)
    );

    register_file register_file_inst (
        .clock    (clock),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .rd_idx   (rd_idx),
        .rd_data  (rd_data),
        .rd_write (rd_write)
    );

    load_store_unit load_store_unit_inst (
        .clock     (clock),
        .reset     (reset),
        .data      (data_bus.requester),
        .start     (ls_start),
        .is_store  (is_store),
        .addr      (ls_addr),
        .wdata     (store_data),
        .done      (ls_done),
        .load_data (load_data)
    );

    mem_arbiter mem_arbiter_inst (
        .clock     (clock),
        .reset     (reset),
        .fetch_bus (fetch_bus.responder),
        .data_bus  (data_bus.responder),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

endmodule

//--- verilog/rv_pkg.sv
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_idx_t;

    // Major opcodes of the supported groups
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_WORD    = 3'b010; // LW and SW only

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB and SRA

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    typedef enum logic [1:0] {
        KIND_REG,
        KIND_LOAD,
        KIND_STORE,
        KIND_ILLEGAL
    } exec_kind_t;

endpackage
